//--- hdl/procPkg.sv
// fixed 16-bit core with 8 registers and 256-word memories; the all-zero word must decode as nop
package procPkg;

        ////////////////////////////////////////
        // widths and sizes
        localparam int dataWidth     = 16;
        localparam int regAddrWidth  = 3;
        localparam int imemDepth     = 256;        // words
        localparam int dmemDepth     = 256;        // words
        localparam int imemAddrWidth = $clog2(imemDepth);
        localparam int dmemAddrWidth = $clog2(dmemDepth);

        ////////////////////////////////////////
        // 5-bit opcodes
        // zero stays nop so flushed slots and reset values are bubbles
        localparam logic [4:0] opNop  = 5'b00000;
        localparam logic [4:0] opHalt = 5'b00001;
        localparam logic [4:0] opJ    = 5'b00100;
        localparam logic [4:0] opAddi = 5'b01000;
        localparam logic [4:0] opBeqz = 5'b01100;
        localparam logic [4:0] opSt   = 5'b10000;
        localparam logic [4:0] opLd   = 5'b10001;
        localparam logic [4:0] opSub  = 5'b11001;
        localparam logic [4:0] opAdd  = 5'b11011;

        // forwarding select codes, 2'b11 unused
        localparam logic [1:0] fwdReg   = 2'b00;
        localparam logic [1:0] fwdExMem = 2'b01;
        localparam logic [1:0] fwdWb    = 2'b10;

        ////////////////////////////////////////
        // instruction word, two views of the same 16 bits
        typedef struct packed {
                logic [4:0]              opcode;
                logic [regAddrWidth-1:0] rs;
                logic [regAddrWidth-1:0] rt;
                logic [regAddrWidth-1:0] rd;
                logic [1:0]              pad;       // ignored
        } rFormatT;

        typedef struct packed {
                logic [4:0]              opcode;
                logic [regAddrWidth-1:0] rs;
                logic [regAddrWidth-1:0] rd;        // also offset [7:5] for beqz and j
                logic [4:0]              imm5;
        } iFormatT;

        typedef union packed {
                rFormatT rFormat;
                iFormatT iFormat;
        } instrWord;

        typedef struct packed {
                logic regWrite;
                logic memRead;
                logic memWrite;
                logic memToReg;
                logic aluSrcImm;                    // b from imm
                logic aluSub;
                logic isBranch;                     // beqz
                logic isJump;
                logic isHalt;
                logic illegal;                      // rides to wb for err
        } ctrlBits;

        ////////////////////////////////////////
        // pipeline registers
        typedef struct packed {
                ctrlBits                 ctrl;
                logic [dataWidth-1:0]    pcPlus2;
                logic [dataWidth-1:0]    rsData;
                logic [dataWidth-1:0]    rtData;
                logic [dataWidth-1:0]    imm;
                logic [regAddrWidth-1:0] rs;
                logic [regAddrWidth-1:0] rt;
                logic [regAddrWidth-1:0] rd;
        } idExReg;

        typedef struct packed {
                ctrlBits                 ctrl;
                logic [dataWidth-1:0]    aluOut;
                logic [dataWidth-1:0]    storeData;
                logic [regAddrWidth-1:0] rd;
        } exMemReg;

        typedef struct packed {
                ctrlBits                 ctrl;
                logic [dataWidth-1:0]    aluOut;
                logic [dataWidth-1:0]    loadData;
                logic [regAddrWidth-1:0] rd;
        } memWbReg;

        typedef struct packed {
                logic                    valid;
                logic [regAddrWidth-1:0] regNum;
                logic [dataWidth-1:0]    data;
        } wbTrace;

endpackage

//--- hdl/fetchStage.sv
// imem is written only while rstN is low; the pc indexes words through bits [8:1] and wraps
`timescale 1ns/1ps

module fetchStage (
        input  logic                                 clk,
        input  logic                                 rstN,
        input  logic                                 hold,      // load-use stall or halt
        input  logic                                 redirect,  // from execute, beats hold
        input  logic [procPkg::dataWidth-1:0]        target,
        input  logic                                 loadEn,
        input  logic [procPkg::imemAddrWidth-1:0]    loadAddr,
        input  logic [procPkg::dataWidth-1:0]        loadData,
        output procPkg::instrWord                    instr,
        output logic [procPkg::dataWidth-1:0]        pcPlus2
);

        logic [procPkg::dataWidth-1:0] pc;
        logic [procPkg::dataWidth-1:0] imem [procPkg::imemDepth];

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        pc <= '0;
                end else if (redirect) begin
                        pc <= target;           // taken beqz or j
                end else if (!hold) begin
                        pc <= pcPlus2;
                end
        end

        // program load port
        always_ff @(posedge clk) begin
                if (loadEn) begin
                        imem[loadAddr] <= loadData;
                end
        end

        assign pcPlus2 = pc + 16'd2;
        // byte pc, word memory
        assign instr   = imem[pc[procPkg::imemAddrWidth:1]];

        // the program may only change while the core sits in reset
        loadOnlyInReset: assert property (@(posedge clk) rstN |-> !loadEn)
                else $error("imem load while core running");

endmodule

//--- hdl/regFile.sv
// register 0 is ordinary; a write and a read of the same register in one cycle return the new value
`timescale 1ns/1ps

module regFile (
        input  logic                                 clk,
        input  logic                                 rstN,
        input  logic [procPkg::regAddrWidth-1:0]     rsAddr,
        input  logic [procPkg::regAddrWidth-1:0]     rtAddr,
        output logic [procPkg::dataWidth-1:0]        rsData,
        output logic [procPkg::dataWidth-1:0]        rtData,
        input  procPkg::wbTrace                      wr        // writeback port
);

        logic [procPkg::dataWidth-1:0] regs [2**procPkg::regAddrWidth];

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        regs <= '{default: '0};
                end else if (wr.valid) begin
                        regs[wr.regNum] <= wr.data;
                end
        end

        // write-through so decode sees the value retiring this cycle
        assign rsData = (wr.valid && wr.regNum == rsAddr) ? wr.data : regs[rsAddr];
        assign rtData = (wr.valid && wr.regNum == rtAddr) ? wr.data : regs[rtAddr];

endmodule

//--- hdl/decodeStage.sv
// combinational decode of the 9-opcode subset; unknown opcodes flag illegal and decode as nop
`timescale 1ns/1ps

module decodeStage (
        input  procPkg::instrWord                    instr,
        input  logic [procPkg::dataWidth-1:0]        pcPlus2,
        input  logic [procPkg::dataWidth-1:0]        rsData,
        input  logic [procPkg::dataWidth-1:0]        rtData,
        output procPkg::idExReg                      decoded,
        output logic                                 illegal
);

        logic [7:0] offset;     // beqz and j displacement

        assign offset = {instr.iFormat.rd, instr.iFormat.imm5};

        always_comb begin
                decoded         = '0;
                illegal         = 1'b0;
                decoded.pcPlus2 = pcPlus2;
                decoded.rsData  = rsData;
                decoded.rtData  = rtData;
                decoded.rs      = instr.rFormat.rs;
                decoded.rt      = instr.rFormat.rt;     // st data lives here too
                decoded.rd      = instr.iFormat.rd;     // i-format default
                decoded.imm     = {{(procPkg::dataWidth-5){instr.iFormat.imm5[4]}},
                                   instr.iFormat.imm5};
                case (instr.rFormat.opcode)
                        procPkg::opAdd: begin
                                decoded.ctrl.regWrite = 1'b1;
                                decoded.rd            = instr.rFormat.rd;
                        end
                        procPkg::opSub: begin
                                decoded.ctrl.regWrite = 1'b1;
                                decoded.ctrl.aluSub   = 1'b1;   // rs minus rt
                                decoded.rd            = instr.rFormat.rd;
                        end
                        procPkg::opAddi: begin
                                decoded.ctrl.regWrite  = 1'b1;
                                decoded.ctrl.aluSrcImm = 1'b1;
                        end
                        procPkg::opLd: begin
                                decoded.ctrl.regWrite  = 1'b1;
                                decoded.ctrl.memRead   = 1'b1;
                                decoded.ctrl.memToReg  = 1'b1;
                                decoded.ctrl.aluSrcImm = 1'b1;  // rs + imm5
                        end
                        procPkg::opSt: begin
                                decoded.ctrl.memWrite  = 1'b1;
                                decoded.ctrl.aluSrcImm = 1'b1;
                        end
                        procPkg::opBeqz: begin
                                decoded.ctrl.isBranch = 1'b1;
                                decoded.imm = {{(procPkg::dataWidth-8){offset[7]}}, offset};
                        end
                        procPkg::opJ: begin
                                decoded.ctrl.isJump = 1'b1;
                                decoded.imm = {{(procPkg::dataWidth-8){offset[7]}}, offset};
                        end
                        procPkg::opHalt: begin
                                decoded.ctrl.isHalt = 1'b1;
                        end
                        procPkg::opNop: begin
                                decoded.ctrl = '0;
                        end
                        default: begin
                                illegal = 1'b1;         // control stays zero
                        end
                endcase
        end

endmodule

//--- hdl/hazardUnit.sv
// combinational load-use detect and forward select; source fields are compared even when unused
`timescale 1ns/1ps

module hazardUnit (
        input  procPkg::idExReg                      idEx,
        input  procPkg::exMemReg                     exMem,
        input  procPkg::memWbReg                     memWb,
        input  logic [procPkg::regAddrWidth-1:0]     ifIdRs,
        input  logic [procPkg::regAddrWidth-1:0]     ifIdRt,
        output logic                                 loadUse,
        output logic [1:0]                           fwdA,
        output logic [1:0]                           fwdB
);

        ////////////////////////////////////////
        // load in EX feeding the instruction in decode
        assign loadUse = idEx.ctrl.memRead && (idEx.rd == ifIdRs || idEx.rd == ifIdRt);

        ////////////////////////////////////////
        // newest writer wins, EX/MEM before MEM/WB
        assign fwdA = (exMem.ctrl.regWrite && exMem.rd == idEx.rs) ? procPkg::fwdExMem :
                      (memWb.ctrl.regWrite && memWb.rd == idEx.rs) ? procPkg::fwdWb    :
                                                                     procPkg::fwdReg;
        assign fwdB = (exMem.ctrl.regWrite && exMem.rd == idEx.rt) ? procPkg::fwdExMem :
                      (memWb.ctrl.regWrite && memWb.rd == idEx.rt) ? procPkg::fwdWb    :
                                                                     procPkg::fwdReg;

endmodule

//--- hdl/executeStage.sv
// combinational EX; only add and sub exist, and the branch target is pcPlus2 plus the 8-bit offset
`timescale 1ns/1ps

module executeStage (
        input  procPkg::idExReg                      idEx,
        input  logic [1:0]                           fwdA,
        input  logic [1:0]                           fwdB,
        input  logic [procPkg::dataWidth-1:0]        exMemAlu,  // one ahead
        input  logic [procPkg::dataWidth-1:0]        wbData,    // two ahead
        output procPkg::exMemReg                     result,
        output logic                                 redirect,
        output logic [procPkg::dataWidth-1:0]        target
);

        logic [procPkg::dataWidth-1:0] opA;
        logic [procPkg::dataWidth-1:0] opB;
        logic [procPkg::dataWidth-1:0] aluB;

        function automatic logic [procPkg::dataWidth-1:0] pickOperand(
                input logic [1:0]                    sel,
                input logic [procPkg::dataWidth-1:0] regVal,
                input logic [procPkg::dataWidth-1:0] exMemVal,
                input logic [procPkg::dataWidth-1:0] wbVal
        );
                case (sel)
                        procPkg::fwdExMem: return exMemVal;
                        procPkg::fwdWb:    return wbVal;
                        default:           return regVal;
                endcase
        endfunction

        assign opA  = pickOperand(fwdA, idEx.rsData, exMemAlu, wbData);
        assign opB  = pickOperand(fwdB, idEx.rtData, exMemAlu, wbData);
        assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;   // addi, ld, st

        always_comb begin
                result.ctrl      = idEx.ctrl;
                result.aluOut    = idEx.ctrl.aluSub ? opA - aluB : opA + aluB;
                result.storeData = opB;                         // forwarded st data
                result.rd        = idEx.rd;
        end

        ////////////////////////////////////////
        // branch and jump resolve here
        assign redirect = idEx.ctrl.isJump | (idEx.ctrl.isBranch & (opA == '0));
        assign target   = idEx.pcPlus2 + idEx.imm;

endmodule

//--- hdl/memoryStage.sv
// single-cycle data memory with no reset contents; only the low 8 address bits are decoded
`timescale 1ns/1ps

module memoryStage (
        input  logic                                 clk,
        input  logic                                 rstN,
        input  procPkg::exMemReg                     exMem,
        output logic [procPkg::dataWidth-1:0]        loadData
);

        logic [procPkg::dataWidth-1:0]     dmem [procPkg::dmemDepth];
        logic [procPkg::dmemAddrWidth-1:0] addr;

        assign addr = exMem.aluOut[procPkg::dmemAddrWidth-1:0];     // word index

        always_ff @(posedge clk) begin
                if (exMem.ctrl.memWrite) begin
                        dmem[addr] <= exMem.storeData;
                end
        end

        assign loadData = dmem[addr];   // read is combinational

        // decode never builds an op that both loads and stores
        noLoadAndStore: assert property (@(posedge clk) disable iff (!rstN)
                        !(exMem.ctrl.memRead && exMem.ctrl.memWrite))
                else $error("memRead and memWrite both set");

endmodule

//--- hdl/proc.sv
// imem is loaded through loadEn while rstN is low; wbOut shows register writes only, in program order
`timescale 1ns/1ps

module proc (
        input  logic                                 clk,
        input  logic                                 rstN,
        input  logic                                 loadEn,
        input  logic [procPkg::imemAddrWidth-1:0]    loadAddr,
        input  logic [procPkg::dataWidth-1:0]        loadData,
        output procPkg::wbTrace                      wbOut,
        output logic                                 halted,
        output logic                                 err
);

        procPkg::instrWord             fetchInstr, ifIdInstr;
        logic [procPkg::dataWidth-1:0] fetchPcPlus2, ifIdPcPlus2;
        logic [procPkg::dataWidth-1:0] rsData, rtData, target, memLoadData, wbData;
        procPkg::idExReg               decoded, idEx;
        procPkg::exMemReg              exResult, exMem;
        procPkg::memWbReg              memWb;
        logic                          illegal, loadUse, redirect;
        logic [1:0]                    fwdA, fwdB;
        logic                          haltSeen, haltStop, haltedReg, errReg;

        // halt in decode or already past it freezes fetch
        assign haltStop = haltSeen | decoded.ctrl.isHalt;

        fetchStage i_fetch (
                .clk(clk), .rstN(rstN),
                .hold(loadUse | haltStop), .redirect(redirect), .target(target),
                .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
                .instr(fetchInstr), .pcPlus2(fetchPcPlus2)
        );

        ////////////////////////////////////////
        // IF/ID, flush beats stall
        always_ff @(posedge clk) begin
                if (!rstN || redirect) begin
                        ifIdInstr <= '0;                // nop
                end else if (!loadUse) begin
                        ifIdInstr   <= haltStop ? '0 : fetchInstr;  // nothing behind halt
                        ifIdPcPlus2 <= fetchPcPlus2;
                end
        end

        regFile i_regFile (
                .clk(clk), .rstN(rstN),
                .rsAddr(ifIdInstr.rFormat.rs), .rtAddr(ifIdInstr.rFormat.rt),
                .rsData(rsData), .rtData(rtData),
                .wr(wbOut)
        );

        decodeStage i_decode (
                .instr(ifIdInstr), .pcPlus2(ifIdPcPlus2),
                .rsData(rsData), .rtData(rtData),
                .decoded(decoded), .illegal(illegal)
        );

        hazardUnit i_hazard (
                .idEx(idEx), .exMem(exMem), .memWb(memWb),
                .ifIdRs(ifIdInstr.rFormat.rs), .ifIdRt(ifIdInstr.rFormat.rt),
                .loadUse(loadUse), .fwdA(fwdA), .fwdB(fwdB)
        );

        ////////////////////////////////////////
        // ID/EX, bubble on flush or load-use
        always_ff @(posedge clk) begin
                if (!rstN || redirect || loadUse) begin
                        idEx.ctrl <= '0;
                end else begin
                        idEx              <= decoded;
                        idEx.ctrl.illegal <= illegal;   // carried for err
                end
        end

        executeStage i_execute (
                .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
                .exMemAlu(exMem.aluOut), .wbData(wbData),
                .result(exResult), .redirect(redirect), .target(target)
        );

        memoryStage i_memory (
                .clk(clk), .rstN(rstN), .exMem(exMem), .loadData(memLoadData)
        );

        ////////////////////////////////////////
        // EX/MEM and MEM/WB, never stalled
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        exMem.ctrl <= '0;
                        memWb.ctrl <= '0;
                end else begin
                        exMem <= exResult;
                        memWb <= '{ctrl: exMem.ctrl, aluOut: exMem.aluOut,
                                   loadData: memLoadData, rd: exMem.rd};
                end
        end

        // writeback mux
        assign wbData = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluOut;

        always_comb begin
                wbOut.valid  = memWb.ctrl.regWrite;
                wbOut.regNum = memWb.rd;
                wbOut.data   = wbData;
        end

        ////////////////////////////////////////
        // sticky halt and err state
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        haltSeen  <= 1'b0;
                        haltedReg <= 1'b0;
                        errReg    <= 1'b0;
                end else begin
                        haltSeen  <= haltSeen | (decoded.ctrl.isHalt & ~redirect & ~loadUse);
                        haltedReg <= halted;
                        errReg    <= err;
                end
        end

        assign halted = haltedReg | memWb.ctrl.isHalt;  // high in the halt's wb cycle
        assign err    = errReg | memWb.ctrl.illegal;

        // nothing younger than halt may retire
        noRetireAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
                        haltedReg |-> !wbOut.valid)
                else $error("register write after halt");

endmodule

//--- sim/refModel.sv
// instruction-level model of the subset; dmem starts at zero, so loads should follow stores
package refModel;

        ////////////////////////////////////////
        // instruction builders
        function automatic logic [15:0] encR(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [2:0] rt, input logic [2:0] rd);
                return {op, rs, rt, rd, 2'b00};
        endfunction

        // addi, ld, st: rd field doubles as st data register
        function automatic logic [15:0] encI(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [2:0] rd, input logic [4:0] imm);
                return {op, rs, rd, imm};
        endfunction

        // beqz and j, byte offset from pc+2
        function automatic logic [15:0] encB(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [7:0] off);
                return {op, rs, off};
        endfunction

        ////////////////////////////////////////
        // run until halt, collect register writes in order
        function automatic void interpret(input logic [15:0] prog [256],
                                          output logic [19:0] writes [64],
                                          output int nWrites, output bit sawIllegal);
                logic [15:0] regs [8];
                logic [15:0] dmem [256];
                logic [15:0] pc, w, ea, val, sImm, sOff;
                logic [4:0]  op;
                bit          done;
                regs       = '{default: '0};
                dmem       = '{default: '0};
                writes     = '{default: '0};
                pc         = '0;
                nWrites    = 0;
                sawIllegal = 1'b0;
                done       = 1'b0;
                for (int step = 0; step < 500 && !done; step++) begin
                        w    = prog[pc[8:1]];
                        op   = w[15:11];
                        sImm = {{11{w[4]}}, w[4:0]};
                        sOff = {{8{w[7]}}, w[7:0]};
                        ea   = regs[w[10:8]] + sImm;
                        pc   = pc + 16'd2;
                        val  = '0;
                        case (op)
                                procPkg::opAdd:  val = regs[w[10:8]] + regs[w[7:5]];
                                procPkg::opSub:  val = regs[w[10:8]] - regs[w[7:5]];
                                procPkg::opAddi: val = ea;
                                procPkg::opLd:   val = dmem[ea[7:0]];
                                procPkg::opSt:   dmem[ea[7:0]] = regs[w[7:5]];
                                procPkg::opBeqz: if (regs[w[10:8]] == '0) pc = pc + sOff;
                                procPkg::opJ:    pc = pc + sOff;
                                procPkg::opHalt: done = 1'b1;
                                procPkg::opNop:  ;
                                default:         sawIllegal = 1'b1;     // acts as nop
                        endcase
                        if (op == procPkg::opAdd || op == procPkg::opSub) begin
                                regs[w[4:2]]      = val;
                                writes[nWrites++] = {1'b1, w[4:2], val};
                        end else if (op == procPkg::opAddi || op == procPkg::opLd) begin
                                regs[w[7:5]]      = val;
                                writes[nWrites++] = {1'b1, w[7:5], val};
                        end
                end
        endfunction

endpackage

//--- sim/procTb.sv
// runs five short programs in turn; each must end in halt within 300 cycles
`timescale 1ns/1ps

module procTb;

        logic                 clk;
        logic                 rstN;
        logic                 loadEn;
        logic [7:0]           loadAddr;
        logic [15:0]          loadData;
        procPkg::wbTrace      wbOut;
        logic                 halted;
        logic                 err;

        logic [15:0]          prog [256];
        logic [19:0]          expected [64];
        logic [19:0]          expNow;
        int                   nExp;
        int                   retired;
        bit                   expErr;
        bit                   cleanRun;
        string                testName;
        int                   checkErrors;
        int                   otherErrors;
        logic [31:0]          lfsrState;

        proc i_proc (
                .clk(clk), .rstN(rstN),
                .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
                .wbOut(wbOut), .halted(halted), .err(err)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;         // 20 ns
        end

        ////////////////////////////////////////
        // retirement tracking
        always @(posedge clk) begin
                if (!rstN) begin
                        retired <= 0;
                end else if (wbOut.valid) begin
                        retired <= retired + 1;
                end
        end

        assign expNow = (retired < nExp) ? expected[retired] : '0;

        // each write matches the next one from the model
        wbMatches: assert property (@(posedge clk) disable iff (!rstN)
                        wbOut.valid |-> (retired < nExp && wbOut == expNow))
                else begin
                        checkErrors++;
                        $display("CHECK FAILED %s: expected %h actual %h",
                                 testName, $sampled(expNow), $sampled(wbOut));
                end

        haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
                else begin
                        otherErrors++;
                        $display("%s: halted dropped after going high", testName);
                end

        quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
                        halted |=> !wbOut.valid)
                else begin
                        otherErrors++;
                        $display("%s: a register write retired after halt", testName);
                end

        errLowWhenClean: assert property (@(posedge clk) disable iff (!rstN) cleanRun |-> !err)
                else begin
                        otherErrors++;
                        $display("%s: err rose in a program with no illegal opcode", testName);
                end

        ////////////////////////////////////////
        // galois lfsr, one step per bit
        function automatic logic [4:0] takeBits(input int n);
                logic [4:0] r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003
                                                 : lfsrState >> 1;
                        r = {r[3:0], lfsrState[0]};
                end
                return r;
        endfunction

        task automatic finishRun();
                $display("closing: %0d check errors, %0d other errors", checkErrors, otherErrors);
                if (checkErrors == 0 && otherErrors == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        endtask

        // reset, load imem, release, wait for halt
        task automatic runProgram(input string name);
                int cycles;
                testName = name;
                refModel::interpret(prog, expected, nExp, expErr);
                @(posedge clk);
                rstN     <= 1'b0;
                cleanRun <= !expErr;
                for (int a = 0; a < 256; a++) begin
                        @(posedge clk);
                        loadEn   <= 1'b1;
                        loadAddr <= a[7:0];
                        loadData <= prog[a];
                end
                @(posedge clk);
                loadEn <= 1'b0;
                repeat (2) @(posedge clk);      // 2 cycles of plain reset
                rstN <= 1'b1;
                cycles = 0;
                while (!halted && cycles < 300) begin
                        @(posedge clk);
                        cycles++;
                end
                if (!halted) begin
                        otherErrors++;
                        $display("%s: timed out waiting for halted", name);
                end else begin
                        // err is already up in the halt's wb cycle
                        assert (err == expErr) else begin
                                checkErrors++;
                                $display("CHECK FAILED %s: expected err %0b actual %0b",
                                         name, expErr, err);
                        end
                        for (int i = 0; i < 10; i++) @(posedge clk);   // watch for stray writes
                        assert (retired == nExp) else begin
                                checkErrors++;
                                $display("CHECK FAILED %s: expected %0d writes actual %0d",
                                         name, nExp, retired);
                        end
                end
        endtask

        ////////////////////////////////////////
        // programs
        initial begin
                rstN        = 1'b0;
                loadEn      = 1'b0;
                loadAddr    = '0;
                loadData    = '0;
                cleanRun    = 1'b0;
                nExp        = 0;
                checkErrors = 0;
                otherErrors = 0;
                lfsrState   = 32'hd503_9ce6;

                // dependent chain, forwards from mem and wb
                prog    = '{default: '0};
                prog[0] = refModel::encI(procPkg::opAddi, 3'd0, 3'd1, takeBits(5));
                prog[1] = refModel::encI(procPkg::opAddi, 3'd1, 3'd2, takeBits(5));
                prog[2] = refModel::encR(procPkg::opAdd, 3'd1, 3'd2, 3'd3);
                prog[3] = refModel::encR(procPkg::opSub, 3'd3, 3'd1, 3'd4);
                prog[4] = refModel::encR(procPkg::opAdd, 3'd4, 3'd3, 3'd5);
                prog[5] = refModel::encI(procPkg::opAddi, 3'd5, 3'd6, takeBits(5));
                prog[6] = refModel::encR(procPkg::opSub, 3'd6, 3'd2, 3'd7);
                prog[7] = {procPkg::opHalt, 11'd0};
                runProgram("aluChain");

                // st then ld, used right away
                prog    = '{default: '0};
                prog[0] = refModel::encI(procPkg::opAddi, 3'd0, 3'd1, takeBits(5));
                prog[1] = refModel::encI(procPkg::opAddi, 3'd0, 3'd2, 5'd5);
                prog[2] = refModel::encI(procPkg::opSt, 3'd2, 3'd1, 5'd3);
                prog[3] = refModel::encI(procPkg::opLd, 3'd2, 3'd3, 5'd3);
                prog[4] = refModel::encR(procPkg::opAdd, 3'd3, 3'd1, 3'd4);
                prog[5] = {procPkg::opHalt, 11'd0};
                runProgram("storeLoad");

                // taken beqz, j, then untaken beqz
                prog     = '{default: '0};
                prog[0]  = refModel::encI(procPkg::opAddi, 3'd0, 3'd1, 5'd0);
                prog[1]  = refModel::encB(procPkg::opBeqz, 3'd1, 8'd4);
                prog[2]  = refModel::encI(procPkg::opAddi, 3'd0, 3'd2, 5'd1);
                prog[3]  = refModel::encI(procPkg::opAddi, 3'd0, 3'd3, 5'd2);
                prog[4]  = refModel::encB(procPkg::opJ, 3'd0, 8'd4);
                prog[5]  = refModel::encI(procPkg::opAddi, 3'd0, 3'd4, 5'd3);
                prog[6]  = refModel::encI(procPkg::opAddi, 3'd0, 3'd5, 5'd4);
                prog[7]  = refModel::encI(procPkg::opAddi, 3'd0, 3'd6, 5'd7);
                prog[8]  = refModel::encB(procPkg::opBeqz, 3'd6, 8'd4);   // not taken
                prog[9]  = refModel::encI(procPkg::opAddi, 3'd0, 3'd2, 5'd5);
                prog[10] = refModel::encI(procPkg::opAddi, 3'd0, 3'd3, 5'd6);
                prog[11] = {procPkg::opHalt, 11'd0};
                runProgram("branchJump");

                // work after halt never retires
                prog    = '{default: '0};
                prog[0] = refModel::encI(procPkg::opAddi, 3'd0, 3'd1, 5'd1);
                prog[1] = {procPkg::opHalt, 11'd0};
                prog[2] = refModel::encI(procPkg::opAddi, 3'd0, 3'd2, 5'd2);
                prog[3] = refModel::encI(procPkg::opAddi, 3'd0, 3'd3, 5'd3);
                runProgram("haltStop");

                // illegal opcode 11111 raises err
                prog    = '{default: '0};
                prog[0] = refModel::encI(procPkg::opAddi, 3'd0, 3'd1, 5'd1);
                prog[1] = 16'hf800;
                prog[2] = refModel::encI(procPkg::opAddi, 3'd1, 3'd2, 5'd1);
                prog[3] = {procPkg::opHalt, 11'd0};
                runProgram("illegalOp");

                finishRun();
        end

endmodule

//--- sources.f
hdl/procPkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/proc.sv
sim/refModel.sv
sim/procTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the processor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module procTb -f sources.f -o procSim
if [ $? -ne 0 ]; then
        echo "verilator compile failed"
        exit 1
fi

output=$(./obj_dir/procSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -qx "test passed" <<< "$output"; then
        exit 0
fi
exit 1
